// ==== hw/phy_rx_pkg.sv ====
/*
 * Shared types and constants for the receive side of the chiplet link PHY.
 * A symbol is written abcdei_fghj with bit a in bit 9.
 */
package phy_rx_pkg;

    typedef logic [9:0]    symbol_t;
    typedef symbol_t [4:0] enc_flit_t;   // Lane 0 in the low bits.
    typedef logic [7:0]    pkt_size_t;
    typedef logic [3:0]    fmt_t;

    typedef struct packed {
        logic        vc;
        logic [1:0]  id;
        logic [4:0]  req;
        logic [31:0] payload;
    } flit_t;

    typedef enum logic [3:0] {
        START_PACKET_SEL,
        END_PACKET_SEL,
        RESEND_PACKET0_SEL,
        RESEND_PACKET1_SEL,
        RESEND_PACKET2_SEL,
        RESEND_PACKET3_SEL,
        ACK_SEL,
        NACK_SEL,
        DATA_SEL
    } comma_sel_t;

    // Negative disparity forms of the K characters.
    localparam symbol_t START_COMMA          = 10'b110110_1000;  // K27.7.
    localparam symbol_t END_COMMA            = 10'b101110_1000;  // K29.7.
    localparam symbol_t RESEND_PACKET0_COMMA = 10'b001111_0100;  // K28.0.
    localparam symbol_t RESEND_PACKET1_COMMA = 10'b001111_1001;  // K28.1.
    localparam symbol_t RESEND_PACKET2_COMMA = 10'b001111_0101;  // K28.2.
    localparam symbol_t RESEND_PACKET3_COMMA = 10'b001111_0011;  // K28.3.
    localparam symbol_t ACK_COMMA            = 10'b001111_0010;  // K28.4.
    localparam symbol_t NACK_COMMA           = 10'b001111_0110;  // K28.6.
    localparam symbol_t K_CODE_MASK          = 10'h3ff;  // Flips a K code to its other disparity.

    localparam fmt_t FMT_LONG_READ   = 4'h1;
    localparam fmt_t FMT_SHORT_READ  = 4'h2;
    localparam fmt_t FMT_LONG_WRITE  = 4'h3;
    localparam fmt_t FMT_MEM_RESP    = 4'h4;
    localparam fmt_t FMT_MSG         = 4'h5;
    localparam fmt_t FMT_SWITCH_CFG  = 4'h6;
    localparam fmt_t FMT_SHORT_WRITE = 4'h7;

    typedef struct packed {
        fmt_t        fmt;
        logic [6:0]  length;
        logic [4:0]  tag;
        logic [15:0] addr_hi;
    } long_hdr_t;

    typedef struct packed {
        fmt_t        fmt;
        logic [3:0]  length;
        logic [23:0] addr;
    } short_hdr_t;

    typedef struct packed {
        fmt_t        fmt;
        logic [6:0]  length;
        logic [7:0]  msg_code;
        logic [12:0] rsvd;
    } msg_hdr_t;

    typedef struct packed {
        fmt_t        fmt;
        logic [4:0]  tag;
        logic [6:0]  length;
        logic [15:0] status;
    } resp_hdr_t;

    typedef struct packed {
        flit_t      flit;
        comma_sel_t comma_sel;
        pkt_size_t  curr_packet_size;
    } rx_flit_t;

endpackage

// ==== hw/dec_8b10b.sv ====
/*
 * 8b/10b decoder for one byte lane. Decodes the 6b and 4b sub-blocks by
 * table, keeps the running disparity and flags bad codes.
 */
`timescale 1ns/1ps

module dec_8b10b import phy_rx_pkg::*; (
    input  symbol_t    data_in,
    output logic [7:0] data_out,
    output logic       k_out,
    output logic       err,
    input  logic       CLK,
    input  logic       nRST
);

    logic [5:0] six;
    logic [3:0] four;
    logic [3:0] four_k;
    logic [4:0] d5;
    logic [2:0] d3;
    logic [2:0] six_ones;
    logic [2:0] four_ones;
    logic       six_bad;
    logic       four_bad;
    logic       disp_err;
    logic       k28;
    logic       rd;         // Running disparity, high when positive.
    logic       rd_mid;
    logic       rd_next;

    assign six       = data_in[9:4];
    assign four      = data_in[3:0];
    assign k28       = (six == 6'b001111) || (six == 6'b110000);
    assign four_k    = (six == 6'b110000) ? ~four : four;  // K28 positive form inverts the 4b part.
    assign six_ones  = 3'($countones(six));
    assign four_ones = 3'($countones(four));

    always_comb begin
        d5      = '0;
        six_bad = 1'b0;
        case (six)
            6'b100111, 6'b011000: d5 = 5'd0;
            6'b011101, 6'b100010: d5 = 5'd1;
            6'b101101, 6'b010010: d5 = 5'd2;
            6'b110001:            d5 = 5'd3;
            6'b110101, 6'b001010: d5 = 5'd4;
            6'b101001:            d5 = 5'd5;
            6'b011001:            d5 = 5'd6;
            6'b111000, 6'b000111: d5 = 5'd7;
            6'b111001, 6'b000110: d5 = 5'd8;
            6'b100101:            d5 = 5'd9;
            6'b010101:            d5 = 5'd10;
            6'b110100:            d5 = 5'd11;
            6'b001101:            d5 = 5'd12;
            6'b101100:            d5 = 5'd13;
            6'b011100:            d5 = 5'd14;
            6'b010111, 6'b101000: d5 = 5'd15;
            6'b011011, 6'b100100: d5 = 5'd16;
            6'b100011:            d5 = 5'd17;
            6'b010011:            d5 = 5'd18;
            6'b110010:            d5 = 5'd19;
            6'b001011:            d5 = 5'd20;
            6'b101010:            d5 = 5'd21;
            6'b011010:            d5 = 5'd22;
            6'b111010, 6'b000101: d5 = 5'd23;
            6'b110011, 6'b001100: d5 = 5'd24;
            6'b100110:            d5 = 5'd25;
            6'b010110:            d5 = 5'd26;
            6'b110110, 6'b001001: d5 = 5'd27;
            6'b001110, 6'b001111,
            6'b110000:            d5 = 5'd28;
            6'b101110, 6'b010001: d5 = 5'd29;
            6'b011110, 6'b100001: d5 = 5'd30;
            6'b101011, 6'b010100: d5 = 5'd31;
            default:              six_bad = 1'b1;
        endcase
    end

    always_comb begin
        d3       = '0;
        four_bad = 1'b0;
        case (four_k)
            4'b1011, 4'b0100:                   d3 = 3'd0;
            4'b1001:                            d3 = 3'd1;
            4'b0101:                            d3 = 3'd2;
            4'b1100, 4'b0011:                   d3 = 3'd3;
            4'b1101, 4'b0010:                   d3 = 3'd4;
            4'b1010:                            d3 = 3'd5;
            4'b0110:                            d3 = 3'd6;
            4'b1110, 4'b0001, 4'b0111, 4'b1000: d3 = 3'd7;
            default:                            four_bad = 1'b1;
        endcase
    end

    // Unbalanced sub-blocks must alternate in sign with the running disparity.
    always_comb begin
        rd_mid   = rd;
        disp_err = 1'b0;
        if (six_ones != 3'd3) begin
            disp_err = (six_ones > 3'd3) == rd;
            rd_mid   = six_ones > 3'd3;
        end
        rd_next = rd_mid;
        if (four_ones != 3'd2) begin
            disp_err = disp_err || ((four_ones > 3'd2) == rd_mid);
            rd_next  = four_ones > 3'd2;
        end
    end

    assign data_out = {d3, d5};
    assign k_out    = k28 || (((four == 4'b0111) || (four == 4'b1000)) &&
                      ((d5 == 5'd23) || (d5 == 5'd27) || (d5 == 5'd29) || (d5 == 5'd30)));
    assign err      = six_bad || four_bad || disp_err;

    // An all-zero symbol marks an idle lane and leaves the disparity alone.
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rd <= 1'b0;
        end else if (data_in != '0) begin
            rd <= rd_next;
        end
    end

endmodule

// ==== hw/rx_flit_decoder.sv ====
/*
 * Flit decoder. Decodes the five lanes, sorts each flit into framing comma,
 * link control comma or data, and predicts the packet length from the header.
 */
`timescale 1ns/1ps

module rx_flit_decoder import phy_rx_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  logic      rx_valid,
    input  enc_flit_t enc_flit,
    input  logic      rx_err_in,
    output rx_flit_t  out,
    output logic      flit_valid,
    output logic      dec_err
);

    localparam int LANES = $bits(enc_flit_t) / $bits(symbol_t);
    localparam symbol_t TWO_FLIT_CODES [6] = '{RESEND_PACKET0_COMMA, RESEND_PACKET1_COMMA,
        RESEND_PACKET2_COMMA, RESEND_PACKET3_COMMA, ACK_COMMA, NACK_COMMA};

    typedef enum logic [1:0] {LOOK_FOR_START, LOOK_FOR_DATA, LOOK_FOR_END} pkt_state_t;

    pkt_state_t          state, n_state;
    enc_flit_t           lane_in;
    logic [LANES-1:0][7:0] lane_byte;
    logic [LANES-1:0]    lane_k;
    logic [LANES-1:0]    lane_err;
    flit_t               flit_data;
    rx_flit_t            n_out;
    comma_sel_t          ctrl_sel;
    logic                one_flit;
    logic                two_flit;
    logic                stray_k;
    long_hdr_t           long_hdr;
    short_hdr_t          short_hdr;
    msg_hdr_t            msg_hdr;
    resp_hdr_t           resp_hdr;
    pkt_size_t           long_len, short_len, msg_len, resp_len;

    function automatic logic sym_match(symbol_t sym, symbol_t code);
        return (sym == code) || (sym == (code ^ K_CODE_MASK));
    endfunction

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        assign lane_in[i] = rx_valid ? enc_flit[i] : '0;
        dec_8b10b dec_i (
            .data_in  (lane_in[i]),
            .data_out (lane_byte[i]),
            .k_out    (lane_k[i]),
            .err      (lane_err[i]),
            .CLK      (CLK),
            .nRST     (nRST)
        );
    end

    assign flit_data = flit_t'(lane_byte);
    assign one_flit  = sym_match(enc_flit[0], START_COMMA) || sym_match(enc_flit[0], END_COMMA);
    assign two_flit  = !one_flit && (ctrl_sel != DATA_SEL);

    // Link control code in lane 1, in enum order from RESEND_PACKET0_SEL.
    always_comb begin
        ctrl_sel = DATA_SEL;
        for (int j = 0; j < 6; j++) begin
            if (sym_match(enc_flit[1], TWO_FLIT_CODES[j]))
                ctrl_sel = comma_sel_t'(RESEND_PACKET0_SEL + j);
        end
    end

    assign long_hdr  = long_hdr_t'(flit_data.payload);
    assign short_hdr = short_hdr_t'(flit_data.payload);
    assign msg_hdr   = msg_hdr_t'(flit_data.payload);
    assign resp_hdr  = resp_hdr_t'(flit_data.payload);
    assign long_len  = (long_hdr.length == '0) ? 8'd128 : pkt_size_t'(long_hdr.length);
    assign short_len = (short_hdr.length == '0) ? 8'd16 : pkt_size_t'(short_hdr.length);
    assign msg_len   = (msg_hdr.length == '0) ? 8'd128 : pkt_size_t'(msg_hdr.length);
    assign resp_len  = (resp_hdr.length == '0) ? 8'd128 : pkt_size_t'(resp_hdr.length);

    always_comb begin
        n_out   = out;
        n_state = state;
        stray_k = 1'b0;
        if (one_flit) begin
            n_out.flit             = '0;
            n_out.curr_packet_size = '0;
            n_out.comma_sel = sym_match(enc_flit[0], START_COMMA) ? START_PACKET_SEL
                                                                  : END_PACKET_SEL;
            n_state = (n_out.comma_sel == START_PACKET_SEL) ? LOOK_FOR_DATA : LOOK_FOR_START;
        end else if (two_flit) begin
            n_out.flit             = '0;
            n_out.flit.vc          = flit_data.payload[7];
            n_out.flit.id          = flit_data.payload[6:5];
            n_out.flit.req         = flit_data.payload[4:0];
            n_out.comma_sel        = ctrl_sel;
            n_out.curr_packet_size = '0;
            stray_k                = lane_k[0];  // Lane 0 must carry a data byte.
        end else begin
            n_out.flit      = flit_data;
            n_out.comma_sel = DATA_SEL;
            stray_k         = |lane_k;
            if (state == LOOK_FOR_DATA) begin
                n_state = LOOK_FOR_END;
                case (fmt_t'(flit_data.payload[31:28]))
                    FMT_LONG_READ:   n_out.curr_packet_size = 8'd2;
                    FMT_SHORT_READ,
                    FMT_SWITCH_CFG:  n_out.curr_packet_size = 8'd1;
                    FMT_LONG_WRITE:  n_out.curr_packet_size = 8'd2 + long_len;
                    FMT_MEM_RESP:    n_out.curr_packet_size = 8'd1 + resp_len;
                    FMT_MSG:         n_out.curr_packet_size = 8'd1 + msg_len;
                    FMT_SHORT_WRITE: n_out.curr_packet_size = 8'd1 + short_len;
                    default:         n_out.curr_packet_size = '0;
                endcase
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            out        <= '{flit: '0, comma_sel: START_PACKET_SEL, curr_packet_size: '0};
            flit_valid <= 1'b0;
            dec_err    <= 1'b0;
            state      <= LOOK_FOR_START;
        end else begin
            flit_valid <= rx_valid && !one_flit;  // Framing commas end here.
            dec_err    <= rx_err_in || (rx_valid && ((|lane_err) || stray_k));
            if (rx_valid) begin
                out   <= n_out;
                state <= n_state;
            end
        end
    end

endmodule

// ==== hw/rx_packet_tracker.sv ====
/*
 * Packet tracker. Counts the data flits of each packet and checks the
 * count against the predicted length when the end comma arrives.
 */
`timescale 1ns/1ps

module rx_packet_tracker import phy_rx_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,
    input  rx_flit_t    in,
    input  logic        flit_valid,
    output logic        pkt_done,
    output logic        len_err,
    output logic [15:0] pkt_count
);

    comma_sel_t prev_sel;
    pkt_size_t  data_count;
    pkt_size_t  exp_size;
    logic       data_flit;
    logic       start_seen;
    logic       end_seen;

    // Framing commas show up only as a change of comma_sel.
    assign data_flit  = flit_valid && (in.comma_sel == DATA_SEL);
    assign start_seen = (in.comma_sel == START_PACKET_SEL) && (prev_sel != START_PACKET_SEL);
    assign end_seen   = (in.comma_sel == END_PACKET_SEL) && (prev_sel != END_PACKET_SEL);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            prev_sel   <= START_PACKET_SEL;
            data_count <= '0;
            exp_size   <= '0;
            pkt_done   <= 1'b0;
            len_err    <= 1'b0;
            pkt_count  <= '0;
        end else begin
            prev_sel <= in.comma_sel;
            pkt_done <= end_seen;
            len_err  <= end_seen && (data_count != exp_size);
            if (end_seen) begin
                pkt_count <= pkt_count + 16'd1;
            end
            if (start_seen || end_seen) begin
                data_count <= '0;
                exp_size   <= '0;
            end else if (data_flit) begin
                data_count <= data_count + 8'd1;
                if (data_count == '0) begin
                    exp_size <= in.curr_packet_size;  // Only the header flit carries it.
                end
            end
        end
    end

endmodule

// ==== hw/phy_rx_top.sv ====
/*
 * Receive path top level. Flit decoder followed by the packet tracker.
 */
`timescale 1ns/1ps

module phy_rx_top import phy_rx_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        rx_valid,
    input  enc_flit_t   enc_flit,
    input  logic        rx_err_in,
    output flit_t       flit,
    output comma_sel_t  comma_sel,
    output logic        flit_valid,
    output logic        dec_err,
    output logic        pkt_done,
    output logic        len_err,
    output logic [15:0] pkt_count
);

    rx_flit_t rx_flit;

    rx_flit_decoder decoder_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .rx_valid   (rx_valid),
        .enc_flit   (enc_flit),
        .rx_err_in  (rx_err_in),
        .out        (rx_flit),
        .flit_valid (flit_valid),
        .dec_err    (dec_err)
    );

    rx_packet_tracker tracker_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .in         (rx_flit),
        .flit_valid (flit_valid),
        .pkt_done   (pkt_done),
        .len_err    (len_err),
        .pkt_count  (pkt_count)
    );

    assign flit      = rx_flit.flit;
    assign comma_sel = rx_flit.comma_sel;

endmodule

// ==== bench/phy_rx_chk.sv ====
/*
 * Output timing assertions for the flit decoder and the packet tracker.
 * Each checker is attached to its module with bind.
 */
`timescale 1ns/1ps

module flit_strobe_chk import phy_rx_pkg::*; (
    input logic     CLK,
    input logic     nRST,
    input logic     rx_valid,
    input logic     flit_valid,
    input rx_flit_t dec_out
);

    a_flit_after_rx: assert property (@(posedge CLK) disable iff (!nRST)
        flit_valid |-> $past(rx_valid))
        else $error("flit_valid without rx_valid in the cycle before.");

    a_no_framing_flit: assert property (@(posedge CLK) disable iff (!nRST)
        flit_valid |-> !(dec_out.comma_sel inside {START_PACKET_SEL, END_PACKET_SEL}))
        else $error("flit_valid raised for a framing comma.");

endmodule

module phy_rx_chk (
    input logic CLK,
    input logic nRST,
    input logic pkt_done,
    input logic len_err
);

    a_done_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        pkt_done |=> !pkt_done)
        else $error("pkt_done held for more than one cycle.");

    a_len_err_with_done: assert property (@(posedge CLK) disable iff (!nRST)
        len_err |-> pkt_done)
        else $error("len_err raised without pkt_done.");

endmodule

bind rx_flit_decoder flit_strobe_chk chk_dec_i (.CLK(CLK), .nRST(nRST), .rx_valid(rx_valid),
    .flit_valid(flit_valid), .dec_out(out));

bind rx_packet_tracker phy_rx_chk chk_trk_i (.CLK(CLK), .nRST(nRST), .pkt_done(pkt_done),
    .len_err(len_err));

// ==== bench/phy_rx_tb.sv ====
/*
 * Testbench for the receive path top level. Replays pre-encoded flits from
 * the cases file, one line per clock, and compares every output.
 */
`timescale 1ns/1ps

module phy_rx_tb import phy_rx_pkg::*; ();

    localparam string CASES_FILE    = "bench/phy_rx_cases.txt";
    localparam int    RESET_TIMEOUT = 40;    // Cycles.
    localparam int    MAX_LINES     = 500;

    logic        CLK;
    logic        nRST;
    logic        rx_valid;
    enc_flit_t   enc_flit;
    logic        rx_err_in;
    flit_t       flit;
    comma_sel_t  comma_sel;
    logic        flit_valid;
    logic        dec_err;
    logic        pkt_done;
    logic        len_err;
    logic [15:0] pkt_count;

    phy_rx_top dut_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .rx_valid   (rx_valid),
        .enc_flit   (enc_flit),
        .rx_err_in  (rx_err_in),
        .flit       (flit),
        .comma_sel  (comma_sel),
        .flit_valid (flit_valid),
        .dec_err    (dec_err),
        .pkt_done   (pkt_done),
        .len_err    (len_err),
        .pkt_count  (pkt_count)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (16) @(posedge CLK);
        #5 nRST = 1'b1;
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped on the first error.");
    endtask

    task automatic check_value(input string name, input logic [39:0] actual,
                               input logic [39:0] expected);
        if (actual !== expected) begin
            stop_run($sformatf("FAILED at %0t: %s is %h, expected %h",
                               $time, name, actual, expected));
        end
    endtask

    initial begin
        int          fd;
        int          line_no;
        int          n_fields;
        int          waited;
        int          cases;
        string       line;
        logic [39:0] col [0:14];

        rx_valid  = 1'b0;
        rx_err_in = 1'b0;
        enc_flit  = '0;
        waited    = 0;
        while (nRST !== 1'b1) begin
            @(posedge CLK);
            waited++;
            if (waited > RESET_TIMEOUT) stop_run("Reset was never released.");
        end
        #1;
        check_value("flit_valid", 40'(flit_valid), 40'd0);
        check_value("comma_sel", 40'(comma_sel), 40'(START_PACKET_SEL));
        check_value("dec_err", 40'(dec_err), 40'd0);
        check_value("pkt_done", 40'(pkt_done), 40'd0);
        check_value("len_err", 40'(len_err), 40'd0);
        check_value("pkt_count", 40'(pkt_count), 40'd0);
        #4;

        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) stop_run("The cases file could not be opened.");
        line_no = 0;
        cases   = 0;
        while (!$feof(fd)) begin
            line_no++;
            if (line_no > MAX_LINES) stop_run("The cases file did not end in time.");
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line[0] == 8'h23) continue;    // Comment or blank line.
            n_fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                col[8], col[9], col[10], col[11], col[12], col[13], col[14]);
            if (n_fields != 15) stop_run($sformatf("Cases file line %0d is malformed.", line_no));
            rx_valid  = col[0][0];
            enc_flit  = {col[1][9:0], col[2][9:0], col[3][9:0], col[4][9:0], col[5][9:0]};
            rx_err_in = col[6][0];
            @(posedge CLK);
            #1;
            check_value("flit_valid", 40'(flit_valid), col[7]);
            check_value("flit", 40'(flit), col[8]);
            check_value("comma_sel", 40'(comma_sel), col[9]);
            check_value("curr_packet_size", 40'(dut_i.rx_flit.curr_packet_size), col[10]);
            check_value("dec_err", 40'(dec_err), col[11]);
            check_value("pkt_done", 40'(pkt_done), col[12]);
            check_value("len_err", 40'(len_err), col[13]);
            check_value("pkt_count", 40'(pkt_count), col[14]);
            cases++;
            #4;
        end
        $fclose(fd);
        rx_valid = 1'b0;
        if (cases == 0) begin
            stop_run("The cases file held no cases.");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// ==== bench/phy_rx_cases.txt ====
# rx_valid lane4 lane3 lane2 lane1 lane0 rx_err_in | expected after that clock edge:
# flit_valid flit comma_sel curr_packet_size dec_err pkt_done len_err pkt_count (all hex)
1 2aa 2aa 2aa 2aa 368 0  0 0000000000 0 00 0 0 0 0000
1 2aa 1b4 2aa 2aa 2aa 0  1 b510b5b5b5 8 02 0 0 0 0000
1 2aa 2aa 2aa 2aa 2aa 0  1 b5b5b5b5b5 8 02 0 0 0 0000
1 2aa 2aa 2aa 2aa 2e8 0  0 0000000000 1 00 0 0 0 0000
0 000 000 000 000 000 0  0 0000000000 1 00 0 1 0 0001
1 2aa 2aa 2aa 2aa 368 0  0 0000000000 0 00 0 0 0 0001
1 2aa 299 2aa 2aa 2aa 0  1 b525b5b5b5 8 01 0 0 0 0001
1 2aa 2aa 2aa 2aa 2aa 0  1 b5b5b5b5b5 8 01 0 0 0 0001
1 2aa 2aa 2aa 2aa 2e8 0  0 0000000000 1 00 0 0 0 0001
0 000 000 000 000 000 0  0 0000000000 1 00 0 1 1 0002
1 2aa 2aa 2aa 2aa 368 0  0 0000000000 0 00 0 0 0 0002
1 2aa 1b4 2aa 2aa 2aa 0  1 b510b5b5b5 8 02 0 0 0 0002
1 2aa 2aa 2aa 0f2 2aa 0  1 b500000000 6 00 0 0 0 0002
1 2aa 2aa 2aa 2aa 2e8 0  0 0000000000 1 00 0 0 0 0002
0 000 000 000 000 000 0  0 0000000000 1 00 0 1 1 0003
1 2aa 2aa 2aa 2aa 368 0  0 0000000000 0 00 0 0 0 0003
1 2aa 239 299 2aa 2aa 0  1 b53125b5b5 8 0b 0 0 0 0003
1 2aa 2aa 2aa 2aa 368 0  0 0000000000 0 00 0 0 0 0003
1 2aa 315 274 2aa 2aa 0  1 b54300b5b5 8 81 0 0 0 0003
1 2aa 2aa 2aa 2aa 368 0  0 0000000000 0 00 0 0 0 0003
1 2aa 135 299 2aa 2aa 0  1 b55225b5b5 8 12 0 0 0 0003
1 2aa 2aa 2aa 2aa 368 0  0 0000000000 0 00 0 0 0 0003
1 2aa 293 2aa 2aa 2aa 0  1 b565b5b5b5 8 01 0 0 0 0003
1 2aa 2aa 2aa 2aa 368 0  0 0000000000 0 00 0 0 0 0003
1 2aa 1b3 2aa 2aa 2aa 0  1 b570b5b5b5 8 11 0 0 0 0003
1 2aa 2aa 2aa 2aa 2e8 0  0 0000000000 1 00 0 0 0 0003
0 000 000 000 000 000 0  0 0000000000 1 00 0 1 1 0004
0 000 000 000 000 000 1  0 0000000000 1 00 1 0 0 0004
1 2aa 2aa 2aa 2aa 3f0 0  1 b5b5b5b500 8 00 1 0 0 0004
0 000 000 000 000 000 0  0 b5b5b5b500 8 00 0 0 0 0004

// ==== project.f ====
hw/phy_rx_pkg.sv
hw/dec_8b10b.sv
hw/rx_flit_decoder.sv
hw/rx_packet_tracker.sv
hw/phy_rx_top.sv
bench/phy_rx_chk.sv
bench/phy_rx_tb.sv

// ==== Makefile ====
# Verilator build and run for the receive path testbench.
# Any variable can be overridden on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= phy_rx_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
